// ==== sources.f ====
hdl/femtoPkg.sv
hdl/coreBusIf.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/loadStoreUnit.sv
hdl/controlFsm.sv
hdl/femtoCore.sv
dv/femtoCoreTb.sv

// ==== Makefile ====
# Verilator build and run of the femtoCore testbench

TOP := femtoCoreTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== dv/femtoCoreTb.sv ====
// Testbench for the multi-cycle RV32I core
// Builds one program from a table of rows, models a word memory with random busy
// stretches and checks every store against a reference
`timescale 1ns/1ns
`default_nettype none

module femtoCoreTb;

   localparam int kReg    = 0;  // R-type ALU op
   localparam int kImm    = 1;  // I-type ALU op
   localparam int kBranch = 2;
   localparam int kJal    = 3;
   localparam int kJalr   = 4;
   localparam int kAuipc  = 5;
   localparam int kLui    = 6;
   localparam int kMem    = 7;  // Word store, narrow store, load back
   localparam int kZero   = 8;  // Write to x0 then read it
   localparam logic [31:0] resultAddr = 32'h0001_0000;  // x5 base

   typedef struct {
      int          kind;
      int          f3;   // ALU, branch or load funct3
      int          alt;  // Instruction bit 30
      int          sf3;  // Store funct3
      int          off;  // Byte offset in the data word
      logic [31:0] a;
      logic [31:0] b;
   } row_t;

   logic        clk = 1'b0;
   logic        reset;
   logic [31:0] memAddr, memWdata, memRdata;
   logic [3:0]  memWmask;
   logic        memRstrb, memRbusy, memWbusy;

   logic [31:0] mem [0:32767];  // 128 KB of words
   row_t        rows [$];
   logic [31:0] expected [$];
   logic [3:0]  storeMasks [$];  // Byte masks of the data word stores, in order
   logic [31:0] pc;             // Program build pointer
   integer      seed = 32'h3ce7f6e7;
   int          resIdx = 0;
   int          rStall = 0;
   int          wStall = 0;
   bit          fetchSeen = 1'b0;
   bit          built = 1'b0;

   femtoCore dut (
      .clk, .reset, .memAddr, .memWdata, .memWmask,
      .memRdata, .memRstrb, .memRbusy, .memWbusy
   );

   initial begin
      forever #20 clk = ~clk;
   end

   task automatic failStop();
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         failStop();
      end
   endtask

   // Instruction encoders
   function automatic logic [31:0] rType(int f7, int rs2, int rs1, int f3, int rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
   endfunction

   function automatic logic [31:0] iType(int imm, int rs1, int f3, int rd, int op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
   endfunction

   function automatic logic [31:0] sType(int imm, int rs2, int rs1, int f3);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] bType(int imm, int rs2, int rs1, int f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] uType(int imm20, int rd, int op);
      return {imm20[19:0], rd[4:0], op[6:0]};
   endfunction

   function automatic logic [31:0] jType(int imm, int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
   endfunction

   function automatic void emit(logic [31:0] instr);
      mem[pc[16:2]] = instr;
      pc = pc + 4;
   endfunction

   function automatic void loadImm(int rd, logic [31:0] val);
      logic [31:0] hi;
      hi = val + 32'h800;  // Offsets the sign-extended ADDI part
      emit(uType(int'(hi >> 12), rd, 'h37));
      emit(iType(int'(val), rd, 0, rd, 'h13));
   endfunction

   // RV32I ALU rule, shift amount from the low 5 bits
   function automatic logic [31:0] aluRef(int f3, int alt, logic [31:0] a, logic [31:0] b);
      case (f3)
         0: return (alt != 0) ? a - b : a + b;
         1: return a << b[4:0];
         2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3: return (a < b) ? 32'd1 : 32'd0;
         4: return a ^ b;
         5: return (alt != 0) ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic bit branchRef(int f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         0: return a == b;
         1: return a != b;
         4: return $signed(a) < $signed(b);
         5: return $signed(a) >= $signed(b);
         6: return a < b;
         default: return a >= b;  // BGEU
      endcase
   endfunction

   // Narrow store of b over word a, then the extended load field
   function automatic logic [31:0] memRef(int sf3, int lf3, int off,
                                          logic [31:0] a, logic [31:0] b);
      logic [31:0] w;
      logic [7:0]  by;
      logic [15:0] hw;
      w = a;
      if (sf3 == 0)
         w[8*off +: 8] = b[7:0];
      else if (sf3 == 1)
         w[16*(off/2) +: 16] = b[15:0];
      else
         w = b;
      by = w[8*off +: 8];
      hw = w[16*(off/2) +: 16];
      case (lf3)
         0: return {{24{by[7]}}, by};   // LB
         1: return {{16{hw[15]}}, hw};  // LH
         4: return {24'b0, by};
         5: return {16'b0, hw};
         default: return w;
      endcase
   endfunction

   function automatic void addRow(int kind, int f3, int alt, int sf3, int off, bit rnd,
                                  logic [31:0] a, logic [31:0] b);
      row_t r;
      r = '{kind, f3, alt, sf3, off, a, b};
      if (rnd) begin
         r.a = $random(seed);
         r.b = $random(seed);
      end
      rows.push_back(r);
   endfunction

   // Operands go to x1 and x2, result to x3, then SW x3 to the result address
   function automatic logic [31:0] buildRow(row_t r);
      logic [31:0] pc0;
      logic [31:0] imm;
      logic [31:0] exp;
      exp = '0;
      loadImm(1, r.a);
      loadImm(2, r.b);
      pc0 = pc;
      case (r.kind)
         kReg: begin
            emit(rType(r.alt * 32, 2, 1, r.f3, 3));
            exp = aluRef(r.f3, r.alt, r.a, r.b);
         end
         kImm: begin
            if ((r.f3 & 3) == 1)
               imm = {21'b0, r.alt[0], 5'b0, r.b[4:0]};  // Shamt, SRAI sets bit 10
            else
               imm = {{20{r.b[11]}}, r.b[11:0]};
            emit(iType(int'(imm), 1, r.f3, 3, 'h13));
            exp = aluRef(r.f3, r.alt, r.a, imm);
         end
         kBranch: begin
            emit(iType(0, 0, 0, 3, 'h13));
            emit(bType(8, 2, 1, r.f3));       // Taken skips the marker
            emit(iType(1, 0, 0, 3, 'h13));   // Marker
            exp = branchRef(r.f3, r.a, r.b) ? 32'd0 : 32'd1;
         end
         kJal: begin
            emit(jType(8, 3));
            emit(iType(1, 0, 0, 3, 'h13));   // Skipped
            exp = pc0 + 4;
         end
         kJalr: begin
            emit(uType(0, 4, 'h17));         // x4 = pc0
            emit(iType(12, 4, 0, 3, 'h67));
            emit(iType(1, 0, 0, 3, 'h13));   // Skipped
            exp = pc0 + 8;
         end
         kAuipc: begin
            emit(uType(int'(r.a >> 12), 3, 'h17));
            exp = (pc0 + {r.a[31:12], 12'b0}) & 32'h00ff_ffff;  // 24-bit PC adder
         end
         kLui: begin
            emit(uType(int'(r.a >> 12), 3, 'h37));
            exp = {r.a[31:12], 12'b0};
         end
         kMem: begin
            emit(sType(256, 1, 5, 2));       // Data word at base + 256
            emit(sType(256 + (r.sf3 == 0 ? r.off : r.sf3 == 1 ? r.off & 2 : 0),
                       2, 5, r.sf3));
            emit(iType(256 + ((r.f3 & 3) == 0 ? r.off : (r.f3 & 3) == 1 ? r.off & 2 : 0),
                       5, r.f3, 3, 'h03));
            exp = memRef(r.sf3, r.f3, r.off, r.a, r.b);
            storeMasks.push_back(4'b1111);
            storeMasks.push_back(r.sf3 == 0 ? 4'b0001 << r.off :      // One byte lane
                                 r.sf3 == 1 ? 4'b0011 << (r.off & 2) : 4'b1111);
         end
         default: begin
            emit(rType(0, 2, 1, 0, 0));      // ADD x0, x1, x2
            emit(rType(0, 0, 0, 0, 3));      // x3 = x0 + x0
         end
      endcase
      emit(sType(0, 3, 5, 2));
      return exp;
   endfunction

   function automatic int pickStall();
      return int'($unsigned($random(seed)) % 3);  // 0 to 2 busy cycles
   endfunction

   // Memory model, requests seen mid-cycle, busy and data driven on the falling edge
   always @(negedge clk) begin
      memRbusy = (rStall > 0);
      memWbusy = (wStall > 0);
      if (rStall > 0) rStall--;
      if (wStall > 0) wStall--;
      if (!reset || !fetchSeen)
         check({28'b0, memWmask}, '0, "write mask before the first fetch");
      if (!reset) begin
         check({31'b0, memRstrb}, '0, "read strobe during reset");
      end else if (memRstrb) begin
         if (!fetchSeen)
            check(memAddr, 32'h0, "first fetch address");
         fetchSeen = 1'b1;
         memRdata  = mem[memAddr[16:2]];
         rStall    = pickStall();
      end
      if (memWmask != '0) begin
         for (int i = 0; i < 4; i++) begin
            if (memWmask[i]) mem[memAddr[16:2]][8*i +: 8] = memWdata[8*i +: 8];
         end
         wStall = pickStall();
         if (memAddr == resultAddr) begin
            if (resIdx >= expected.size()) begin
               $display("The core stored to the result address after the last row");
               failStop();
            end else begin
               check(memWdata, expected[resIdx], $sformatf("row %0d kind %0d funct3 %0d",
                     resIdx, rows[resIdx].kind, rows[resIdx].f3));
               resIdx++;
            end
         end else if (storeMasks.size() == 0) begin
            $display("The core stored to the data word when no store was expected");
            failStop();
         end else begin
            check({28'b0, memWmask}, {28'b0, storeMasks[0]}, "store byte mask");
            storeMasks.delete(0);
         end
      end
   end

   initial begin
      reset    = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      foreach (mem[i]) mem[i] = '0;
      repeat (3) begin
         for (int f = 0; f < 8; f++) begin
            addRow(kReg, f, 0, 0, 0, 1, 0, 0);
            addRow(kImm, f, 0, 0, 0, 1, 0, 0);
         end
         addRow(kReg, 0, 1, 0, 0, 1, 0, 0);  // SUB
         addRow(kReg, 5, 1, 0, 0, 1, 0, 0);  // SRA
         addRow(kImm, 5, 1, 0, 0, 1, 0, 0);  // SRAI
      end
      addRow(kReg, 5, 1, 0, 0, 0, 32'h8000_0000, 31);
      addRow(kReg, 2, 0, 0, 0, 0, 32'hffff_ffff, 1);
      addRow(kReg, 3, 0, 0, 0, 0, 32'hffff_ffff, 1);
      addRow(kImm, 3, 0, 0, 0, 0, 5, 32'hffff_ffff);  // SLTIU against -1
      // SLL, then SRL, then SRA, each by every amount
      for (int s = 0; s < 96; s++)
         addRow(kReg, (s < 32) ? 1 : 5, (s >= 64) ? 1 : 0, 0, 0, 0, 32'h9234_5671, s % 32);
      for (int f = 0; f < 8; f++) begin
         if (f != 2 && f != 3) begin
            addRow(kBranch, f, 0, 0, 0, 0, 7, 7);
            addRow(kBranch, f, 0, 0, 0, 0, 32'hffff_fffd, 2);
            addRow(kBranch, f, 0, 0, 0, 0, 2, 32'hffff_fffd);
            addRow(kBranch, f, 0, 0, 0, 1, 0, 0);
         end
      end
      addRow(kJal, 0, 0, 0, 0, 0, 0, 0);
      addRow(kJalr, 0, 0, 0, 0, 0, 0, 0);
      addRow(kAuipc, 0, 0, 0, 0, 1, 0, 0);
      addRow(kLui, 0, 0, 0, 0, 1, 0, 0);
      addRow(kZero, 0, 0, 0, 0, 1, 0, 0);
      for (int sf = 0; sf < 3; sf++)
         for (int off = 0; off < 4; off++)
            for (int lf = 0; lf < 6; lf++)
               if (lf != 3) addRow(kMem, lf, 0, sf, off, 1, 0, 0);
      pc = '0;
      emit(uType('h10, 5, 'h37));            // x5 = result base
      foreach (rows[i]) expected.push_back(buildRow(rows[i]));
      emit(jType(0, 0));                     // Park in a self loop
      built = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;
      wait (resIdx == expected.size());
      repeat (4) @(posedge clk);
      $display("test passed");
      $finish;
   end

   // Up to 40 instructions of 8 cycles per row
   initial begin
      wait (built);
      repeat (rows.size() * 40 * 8) @(posedge clk);
      $display("Timeout, the core stopped storing results after %0d rows", resIdx);
      failStop();
   end

endmodule

`default_nettype wire

// ==== hdl/femtoCore.sv ====
// Top level of the multi-cycle RV32I core
// Connects control, register file, ALU and load/store unit to one memory port
`timescale 1ns/1ns
`default_nettype none

module femtoCore (
   input  logic        clk,
   input  logic        reset,     // Active low
   output logic [31:0] memAddr,
   output logic [31:0] memWdata,
   output logic [3:0]  memWmask,  // One bit per byte lane
   input  logic [31:0] memRdata,
   output logic        memRstrb,  // One-cycle read request
   input  logic        memRbusy,
   input  logic        memWbusy
);
   import femtoPkg::*;

   logic                    storeEnable, operandLatch, writeBack, predicate;
   logic [regAddrWidth-1:0] rdId;
   word_t                   fetchWord, wbData;
   word_t                   aluOut, aluPlus, loadAddr, loadData;

   coreBusIf bus ();

   controlFsm ctrl (
      .clk, .reset, .bus(bus.ctrl),
      .memRdata, .memRbusy, .memWbusy,
      .aluOut, .aluPlus, .loadAddr, .loadData, .predicate,
      .memAddr, .memRstrb, .storeEnable,
      .operandLatch, .fetchWord, .writeBack, .rdId, .wbData
   );

   regFile regs (
      .clk, .bus(bus.regs),
      .operandLatch, .fetchWord, .writeBack, .rdId, .wbData
   );

   aluUnit alu (.bus(bus.exec), .aluOut, .aluPlus, .predicate);

   loadStoreUnit lsu (
      .bus(bus.exec), .storeEnable, .memRdata,
      .loadAddr, .loadData, .memWdata, .memWmask
   );

endmodule

`default_nettype wire

// ==== hdl/controlFsm.sv ====
// Control state machine of the multi-cycle core
// Holds state, PC and instruction register, selects next PC and write-back value
`timescale 1ns/1ns
`default_nettype none

module controlFsm (
   input  logic                              clk,
   input  logic                              reset,
   coreBusIf.ctrl                            bus,
   input  femtoPkg::word_t                   memRdata,
   input  logic                              memRbusy,
   input  logic                              memWbusy,
   input  femtoPkg::word_t                   aluOut,
   input  femtoPkg::word_t                   aluPlus,
   input  femtoPkg::word_t                   loadAddr,
   input  femtoPkg::word_t                   loadData,
   input  logic                              predicate,
   output logic [31:0]                       memAddr,
   output logic                              memRstrb,
   output logic                              storeEnable,
   output logic                              operandLatch,
   output femtoPkg::word_t                   fetchWord,
   output logic                              writeBack,
   output logic [femtoPkg::regAddrWidth-1:0] rdId,
   output femtoPkg::word_t                   wbData
);
   import femtoPkg::*;

   coreState_t state;
   addr_t      pc;
   instr_t     instr;
   logic [4:0] opcode;
   logic       isLoad, isAluImm, isAuipc, isStore, isAluReg;
   logic       isLui, isBranch, isJalr, isJal;
   logic       fetching;
   word_t      uImm, jImm, bImm;
   addr_t      pcPlus4, pcPlusImm, pcNext;

   assign opcode   = instr.rView.opcode[6:2];
   assign isLoad   = (opcode == opLoad);
   assign isAluImm = (opcode == opAluImm);
   assign isAuipc  = (opcode == opAuipc);
   assign isStore  = (opcode == opStore);
   assign isAluReg = (opcode == opAluReg);
   assign isLui    = (opcode == opLui);
   assign isBranch = (opcode == opBranch);
   assign isJalr   = (opcode == opJalr);
   assign isJal    = (opcode == opJal);

   assign uImm = {instr[31:12], 12'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign bImm = {{20{instr.sView.immHigh[6]}}, instr.sView.immLow[0],
                  instr.sView.immHigh[5:0], instr.sView.immLow[4:1], 1'b0};

   // Shared adder for branch, JAL and AUIPC
   assign pcPlus4   = pc + addr_t'(4);
   assign pcPlusImm = pc + (isJal   ? jImm[addrWidth-1:0] :
                            isAuipc ? uImm[addrWidth-1:0] : bImm[addrWidth-1:0]);
   assign pcNext    = isJalr                       ? {aluPlus[addrWidth-1:1], 1'b0} :
                      (isJal | isBranch & predicate) ? pcPlusImm : pcPlus4;

   assign fetching = (state == fetchInstr) || (state == waitInstr);
   assign memAddr  = {{(xlen-addrWidth){1'b0}}, fetching ? pc : loadAddr[addrWidth-1:0]};
   assign memRstrb = (state == fetchInstr) || (state == execute && isLoad);
   assign storeEnable  = (state == execute) && isStore;
   assign operandLatch = (state == waitInstr) && !memRbusy;  // Instruction word arrived
   assign fetchWord    = memRdata;
   assign bus.instr    = instr;

   // Loads write back when leaving waitMem, others in execute
   assign writeBack = (state == execute && !(isLoad | isStore | isBranch)) ||
                      (state == waitMem && isLoad && !memRbusy && !memWbusy);
   assign rdId      = instr.rView.rd;
   assign wbData    = (isLui              ? uImm                                 : '0) |
                      (isAluImm | isAluReg ? aluOut                              : '0) |
                      (isAuipc            ? {{(xlen-addrWidth){1'b0}}, pcPlusImm} : '0) |
                      (isJal | isJalr     ? {{(xlen-addrWidth){1'b0}}, pcPlus4}   : '0) |
                      (isLoad             ? loadData                             : '0);

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= waitMem;  // Wait for memory idle before first fetch
         pc    <= resetAddr;
      end else begin
         unique case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRbusy) begin
                  state <= execute;
               end
            end
            execute: begin
               pc    <= pcNext;
               state <= (isLoad | isStore) ? waitMem : fetchInstr;
            end
            waitMem: begin
               if (!memRbusy && !memWbusy) begin
                  state <= fetchInstr;
               end
            end
            default: state <= waitMem;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (operandLatch) begin
         instr <= memRdata;  // Same cycle the register file latches operands
      end
   end

   assert property (@(posedge clk) disable iff (!reset)
                    state inside {fetchInstr, waitInstr, execute, waitMem})
      else $error("State not one-hot");

   // Every write strobe is followed by the memory wait state
   assert property (@(posedge clk) disable iff (!reset)
                    storeEnable |-> (state == execute) ##1 (state == waitMem))
      else $error("Store outside execute");

endmodule

`default_nettype wire

// ==== hdl/loadStoreUnit.sv ====
// Load/store alignment for the word-wide memory port
// Effective address, replicated store data with byte mask, and load extraction
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit (
   coreBusIf.exec          bus,
   input  logic            storeEnable,  // Execute cycle of a store
   input  femtoPkg::word_t memRdata,
   output femtoPkg::word_t loadAddr,
   output femtoPkg::word_t loadData,
   output femtoPkg::word_t memWdata,
   output logic [3:0]      memWmask
);
   import femtoPkg::*;

   logic        isStore;
   logic        byteAccess, halfAccess;
   logic        loadSign;
   word_t       iImm, sImm;
   addr_t       addr;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic [3:0]  storeMask;

   assign isStore    = (bus.instr.sView.opcode[6:2] == opStore);
   assign byteAccess = (bus.instr.sView.funct3[1:0] == 2'b00);
   assign halfAccess = (bus.instr.sView.funct3[1:0] == 2'b01);

   // Stores use the split immediate, loads the I-immediate
   assign iImm = {{21{bus.instr.rView.funct7[6]}}, bus.instr.rView.funct7[5:0],
                  bus.instr.rView.rs2};
   assign sImm = {{21{bus.instr.sView.immHigh[6]}}, bus.instr.sView.immHigh[5:0],
                  bus.instr.sView.immLow};

   assign addr     = bus.rs1Val[addrWidth-1:0] +
                     (isStore ? sImm[addrWidth-1:0] : iImm[addrWidth-1:0]);
   assign loadAddr = {{(xlen-addrWidth){1'b0}}, addr};

   // Loads
   assign loadHalf = addr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = addr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !bus.instr.rView.funct3[2] &
                     (byteAccess ? loadByte[7] : loadHalf[15]);  // funct3[2] set for LBU/LHU
   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

   // Store bytes replicated so every lane sees the right data
   assign memWdata[7:0]   = bus.rs2Val[7:0];
   assign memWdata[15:8]  = addr[0] ? bus.rs2Val[7:0] : bus.rs2Val[15:8];
   assign memWdata[23:16] = addr[1] ? bus.rs2Val[7:0] : bus.rs2Val[23:16];
   assign memWdata[31:24] = addr[0] ? bus.rs2Val[7:0] :
                            addr[1] ? bus.rs2Val[15:8] : bus.rs2Val[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << addr[1:0];
      end else if (halfAccess) begin
         storeMask = addr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;     // Word
      end
   end

   assign memWmask = {4{storeEnable}} & storeMask;

endmodule

`default_nettype wire

// ==== hdl/aluUnit.sv ====
// ALU for RV32I register and immediate operations
// One 33-bit subtractor serves SUB and all compares, one shifter serves both directions
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
   coreBusIf.exec          bus,
   output femtoPkg::word_t aluOut,
   output femtoPkg::word_t aluPlus,    // Also JALR target
   output logic            predicate   // Branch taken
);
   import femtoPkg::*;

   word_t       aluIn1, aluIn2;
   word_t       iImm;
   word_t       shifterIn, shifter, leftShift;
   logic [32:0] aluMinus;
   logic signed [32:0] shiftExt;
   logic        lt, ltu, eq;
   logic        isSub;
   logic [2:0]  funct3;
   logic [7:0]  funct3Is;  // One-hot funct3

   function automatic word_t flip32(input word_t x);
      word_t r;
      for (int i = 0; i < xlen; i++) begin
         r[i] = x[xlen-1-i];
      end
      return r;
   endfunction

   assign funct3   = bus.instr.rView.funct3;
   assign funct3Is = 8'b0000_0001 << funct3;
   assign iImm     = {{21{bus.instr.rView.funct7[6]}}, bus.instr.rView.funct7[5:0],
                      bus.instr.rView.rs2};

   // Register ops and branches compare rs2, everything else adds the I-immediate
   assign aluIn1 = bus.rs1Val;
   assign aluIn2 = (bus.instr.rView.opcode[6:2] == opAluReg ||
                    bus.instr.rView.opcode[6:2] == opBranch) ? bus.rs2Val : iImm;

   assign aluPlus  = aluIn1 + aluIn2;
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, aluIn1} + 33'd1;
   assign lt  = (aluIn1[31] ^ aluIn2[31]) ? aluIn1[31] : aluMinus[32];  // Signs differ
   assign ltu = aluMinus[32];
   assign eq  = (aluMinus[31:0] == '0);

   // Bit 30 selects SUB, bit 5 excludes ADDI whose immediate overlaps it
   assign isSub = bus.instr[30] & bus.instr[5];

   // Left shift runs the right shifter on reversed bits
   assign shifterIn = funct3Is[1] ? flip32(aluIn1) : aluIn1;
   assign shiftExt  = $signed({bus.instr[30] & aluIn1[31], shifterIn}) >>> aluIn2[4:0];
   assign shifter   = shiftExt[31:0];
   assign leftShift = flip32(shifter);

   always_comb begin
      unique case (funct3)
         3'd0:    aluOut = isSub ? aluMinus[31:0] : aluPlus;
         3'd1:    aluOut = leftShift;
         3'd2:    aluOut = {{(xlen-1){1'b0}}, lt};
         3'd3:    aluOut = {{(xlen-1){1'b0}}, ltu};
         3'd4:    aluOut = aluIn1 ^ aluIn2;
         3'd5:    aluOut = shifter;    // SRL or SRA
         3'd6:    aluOut = aluIn1 | aluIn2;
         default: aluOut = aluIn1 & aluIn2;
      endcase
   end

   assign predicate = funct3Is[0] &  eq  |  // BEQ
                      funct3Is[1] & !eq  |  // BNE
                      funct3Is[4] &  lt  |  // BLT
                      funct3Is[5] & !lt  |  // BGE
                      funct3Is[6] &  ltu |  // BLTU
                      funct3Is[7] & !ltu;   // BGEU

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
// Integer register file, 32 words with x0 reading as zero
// Operands are latched from the fetched word, results written on writeBack
`timescale 1ns/1ns
`default_nettype none

module regFile (
   input  logic                                clk,
   coreBusIf.regs                              bus,
   input  logic                                operandLatch,  // Fetch word is valid
   input  femtoPkg::word_t                     fetchWord,
   input  logic                                writeBack,
   input  logic [femtoPkg::regAddrWidth-1:0]   rdId,
   input  femtoPkg::word_t                     wbData
);
   import femtoPkg::*;

   word_t  regs [0:(1 << regAddrWidth)-1];
   instr_t fetched;

   assign fetched = fetchWord;  // Decode rs1/rs2 straight from memory data

   always_ff @(posedge clk) begin
      if (writeBack && rdId != '0) begin  // x0 never written
         regs[rdId] <= wbData;
      end
   end

   // Index 0 may hold anything in the array, so force zero on read
   always_ff @(posedge clk) begin
      if (operandLatch) begin
         bus.rs1Val <= (fetched.rView.rs1 == '0) ? '0 : regs[fetched.rView.rs1];
         bus.rs2Val <= (fetched.rView.rs2 == '0) ? '0 : regs[fetched.rView.rs2];
      end
   end

   // x0 operand seen by the execution units
   assert property (@(posedge clk) operandLatch && fetched.rView.rs1 == '0
                    |=> bus.rs1Val == '0)
      else $error("x0 operand not zero");

endmodule

`default_nettype wire

// ==== hdl/coreBusIf.sv ====
// Internal core bus
// Latched instruction from the controller, operand values from the register file
`timescale 1ns/1ns
`default_nettype none

interface coreBusIf;
   import femtoPkg::*;

   instr_t instr;   // Current instruction
   word_t  rs1Val;  // First operand
   word_t  rs2Val;  // Second operand, also store data

   modport ctrl (
      output instr,
      input  rs1Val,
      input  rs2Val
   );

   modport regs (
      output rs1Val,
      output rs2Val
   );

   modport exec (input instr, input rs1Val, input rs2Val);

endinterface

`default_nettype wire

// ==== hdl/femtoPkg.sv ====
// Shared definitions for the multi-cycle RV32I core
// Widths, opcode classes, one-hot state codes and the instruction word views
`default_nettype none

package femtoPkg;

   localparam int xlen         = 32;  // Data width
   localparam int addrWidth    = 24;  // Significant address bits, rest padded with zero
   localparam int regAddrWidth = 5;   // Register index width

   typedef logic [xlen-1:0]      word_t;
   typedef logic [addrWidth-1:0] addr_t;

   localparam addr_t resetAddr = '0;  // PC after reset

   // Opcode classes, taken from instruction bits 6:2
   localparam logic [4:0] opLoad   = 5'b00000;  // rd <- mem[rs1+Iimm]
   localparam logic [4:0] opAluImm = 5'b00100;  // rd <- rs1 OP Iimm
   localparam logic [4:0] opAuipc  = 5'b00101;  // rd <- PC + Uimm
   localparam logic [4:0] opStore  = 5'b01000;  // mem[rs1+Simm] <- rs2
   localparam logic [4:0] opAluReg = 5'b01100;  // rd <- rs1 OP rs2
   localparam logic [4:0] opLui    = 5'b01101;  // rd <- Uimm
   localparam logic [4:0] opBranch = 5'b11000;  // if (rs1 OP rs2) PC <- PC + Bimm
   localparam logic [4:0] opJalr   = 5'b11001;  // rd <- PC+4, PC <- rs1 + Iimm
   localparam logic [4:0] opJal    = 5'b11011;  // rd <- PC+4, PC <- PC + Jimm

   // One-hot control states
   typedef enum logic [3:0] {
      fetchInstr = 4'b0001,  // Read strobe on PC
      waitInstr  = 4'b0010,  // Wait for the instruction word
      execute    = 4'b0100,
      waitMem    = 4'b1000   // Load/store completion, also the reset state
   } coreState_t;

   // Register and I-type view
   typedef struct packed {
      logic [6:0] funct7;  // Also upper I-immediate bits
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rView_t;

   // Split-immediate view used by stores and branches
   typedef struct packed {
      logic [6:0] immHigh;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLow;
      logic [6:0] opcode;
   } sView_t;

   typedef union packed {
      rView_t rView;
      sView_t sView;
   } instr_t;

endpackage

`default_nettype wire
